/* source/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// The cache holds 2**FETCH_INDEX_BITS one-word lines
`define FETCH_INDEX_BITS 6

// Entries in the fetch queue between the cache and decode
`define FETCH_QUEUE_DEPTH 4

// First address fetched after reset
`define FETCH_RESET_VECTOR 32'h0000_0100

`endif

/* source/fetch_pkg.sv */
package fetch_pkg;

	// Byte address as seen by the core
	typedef logic [31:0] addr_t;

	// One instruction word
	typedef logic [31:0] instr_t;

	// The queue hands decode the instruction and where it came from
	typedef struct packed {
		addr_t  pc;
		instr_t instr;
	} fetch_entry_t;

endpackage

/* source/mem_bus_pkg.sv */
package mem_bus_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_word_t;

	// Word-aligned address with bit 0 set as the valid mark
	typedef logic [31:0] tag_t;

	typedef struct packed {
		logic      req;
		bus_addr_t addr;
	} bus_req_t;

	typedef struct packed {
		logic      ready;
		bus_word_t rdata;
	} bus_rsp_t;

	typedef struct packed {
		bus_word_t instr;
		tag_t      tag;
	} cache_line_t;

endpackage

/* source/cache_ram.sv */
`include "fetch_consts.svh"

`timescale 1ns/1ps

module cache_ram #(
	parameter int DEPTH_BITS = `FETCH_INDEX_BITS
) (
	input logic i_clock,
	input logic i_rst,
	input logic i_rw,
	input logic [DEPTH_BITS-1:0] i_address,
	input mem_bus_pkg::cache_line_t i_wdata,
	output mem_bus_pkg::cache_line_t o_rdata,
	output logic o_initialized
);
	import mem_bus_pkg::*;

	localparam int DEPTH = 1 << DEPTH_BITS;

	cache_line_t mem [DEPTH];
	logic [DEPTH_BITS-1:0] clear_index;

	// After reset every line is walked once and zeroed
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			clear_index <= '0;
			o_initialized <= 1'b0;
		end else if (!o_initialized) begin
			clear_index <= clear_index + 1'b1;
			if (clear_index == DEPTH_BITS'(DEPTH - 1)) begin
				o_initialized <= 1'b1;
			end
		end
	end

	// The clearing walk takes the single port until it is done
	always_ff @(posedge i_clock) begin
		if (!o_initialized) begin
			mem[clear_index] <= '0;
		end else if (i_rw) begin
			mem[i_address] <= i_wdata;
		end else begin
			o_rdata <= mem[i_address];
		end
	end

	a_no_write_before_init: assert property (
		@(posedge i_clock) disable iff (i_rst)
		i_rw |-> o_initialized
	) else $error("cache_ram written while still clearing");

endmodule

/* source/instr_cache.sv */
`include "fetch_consts.svh"

`timescale 1ns/1ps

module instr_cache (
	input logic i_clock,
	input logic i_rst,
	input fetch_pkg::addr_t i_pc,
	input logic i_stall,
	output logic o_ready,
	output fetch_pkg::instr_t o_rdata,
	output mem_bus_pkg::bus_req_t o_bus_req,
	input mem_bus_pkg::bus_rsp_t i_bus_rsp,
	output logic o_ram_rw,
	output logic [`FETCH_INDEX_BITS-1:0] o_ram_address,
	output mem_bus_pkg::cache_line_t o_ram_wdata,
	input mem_bus_pkg::cache_line_t i_ram_rdata,
	input logic i_ram_initialized
);
	import fetch_pkg::*;
	import mem_bus_pkg::*;

	localparam int INDEX_BITS = `FETCH_INDEX_BITS;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ_SETUP,
		ST_READ_PREFETCH,
		ST_READ_BUS
	} cache_state_t;

	cache_state_t state;
	cache_state_t next_state;
	addr_t lookup_pc;
	addr_t next_pc;
	logic tag_hit;

	// A cleared line has bit 0 low and so never matches
	function automatic tag_t make_tag(input addr_t address);
		return {address[31:2], 2'b01};
	endfunction

	assign next_pc = i_pc + 32'd4;
	assign tag_hit = (i_ram_rdata.tag == make_tag(i_pc));

	// Index bits sit just above the byte offset
	assign o_ram_address = lookup_pc[INDEX_BITS+1:2];

	// The pc only moves on a delivery, so it doubles as the bus address
	assign o_bus_req = '{req: (state == ST_READ_BUS), addr: i_pc};

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		o_ready = 1'b0;
		o_rdata = '0;
		o_ram_rw = 1'b0;
		o_ram_wdata = '0;
		lookup_pc = i_pc;

		case (state)
			ST_IDLE: begin
				if (!i_stall) begin
					next_state = i_ram_initialized ? ST_READ_SETUP : ST_READ_BUS;
				end
			end

			ST_READ_SETUP: begin
				if (tag_hit) begin
					o_ready = 1'b1;
					o_rdata = i_ram_rdata.instr;
					lookup_pc = next_pc;
					next_state = ST_READ_PREFETCH;
				end else begin
					next_state = ST_READ_BUS;
				end
			end

			// The line for pc+4 was addressed on the previous hit
			ST_READ_PREFETCH: begin
				if (i_stall) begin
					next_state = ST_IDLE;
				end else if (tag_hit) begin
					o_ready = 1'b1;
					o_rdata = i_ram_rdata.instr;
					lookup_pc = next_pc;
				end else begin
					next_state = ST_READ_BUS;
				end
			end

			ST_READ_BUS: begin
				if (i_bus_rsp.ready) begin
					// Words fetched while the RAM is still clearing are not kept
					o_ram_rw = i_ram_initialized;
					o_ram_wdata = '{instr: i_bus_rsp.rdata, tag: make_tag(i_pc)};
					o_ready = 1'b1;
					o_rdata = i_bus_rsp.rdata;
					next_state = ST_IDLE;
				end
			end

			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	a_req_held_until_ready: assert property (
		@(posedge i_clock) disable iff (i_rst)
		o_bus_req.req && !i_bus_rsp.ready |=> o_bus_req.req && $stable(o_bus_req.addr)
	) else $error("bus request dropped or moved before ready");

	a_no_ready_in_idle: assert property (
		@(posedge i_clock) disable iff (i_rst)
		(state == ST_IDLE || i_stall) |-> !o_ready
	) else $error("instruction delivered from idle or while stalled");

endmodule

/* source/pc_sequencer.sv */
`include "fetch_consts.svh"

`timescale 1ns/1ps

module pc_sequencer (
	input logic i_clock,
	input logic i_rst,
	input logic i_ready,
	input logic i_redirect,
	input fetch_pkg::addr_t i_redirect_pc,
	output fetch_pkg::addr_t o_pc,
	output logic o_flush
);
	import fetch_pkg::*;

	addr_t target_pc;
	logic target_pending;

	// The redirect lands on the next delivery, which also throws away what was queued
	assign o_flush = i_ready && target_pending;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_pc <= `FETCH_RESET_VECTOR;
		end else if (o_flush) begin
			o_pc <= target_pc;
		end else if (i_ready) begin
			o_pc <= o_pc + 32'd4;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			target_pending <= 1'b0;
		end else if (i_redirect) begin
			target_pending <= 1'b1;
		end else if (o_flush) begin
			target_pending <= 1'b0;
		end
	end

	// A later redirect replaces one that has not landed yet
	always_ff @(posedge i_clock) begin
		if (i_redirect) begin
			target_pc <= i_redirect_pc;
		end
	end

	a_pc_aligned: assert property (
		@(posedge i_clock) disable iff (i_rst)
		i_ready |=> o_pc[1:0] == 2'b00
	) else $error("fetch address not word aligned");

endmodule

/* source/fetch_queue.sv */
`include "fetch_consts.svh"

`timescale 1ns/1ps

module fetch_queue (
	input logic i_clock,
	input logic i_rst,
	input logic i_push,
	input fetch_pkg::fetch_entry_t i_entry,
	input logic i_flush,
	input logic i_pop,
	output fetch_pkg::fetch_entry_t o_entry,
	output logic o_valid,
	output logic o_stall
);
	import fetch_pkg::*;

	localparam int DEPTH = `FETCH_QUEUE_DEPTH;
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	fetch_entry_t entries [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_BITS-1:0] ptr_step(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign o_valid = (count != '0);
	assign o_stall = (count == COUNT_BITS'(DEPTH));
	assign o_entry = entries[rd_ptr];

	// Flush wins over both push and pop in the same cycle
	assign do_push = i_push && !i_flush && !o_stall;
	assign do_pop = i_pop && o_valid && !i_flush;

	always_ff @(posedge i_clock) begin
		if (i_rst || i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_step(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_step(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push) begin
			entries[wr_ptr] <= i_entry;
		end
	end

	a_no_push_when_full: assert property (
		@(posedge i_clock) disable iff (i_rst)
		i_push && !i_flush |-> !o_stall
	) else $error("fetch queue pushed while full");

endmodule

/* source/fetch_top.sv */
`include "fetch_consts.svh"

`timescale 1ns/1ps

module fetch_top (
	input logic i_clock,
	input logic i_rst,
	input logic i_redirect,
	input fetch_pkg::addr_t i_redirect_pc,
	input logic i_pop,
	output fetch_pkg::fetch_entry_t o_entry,
	output logic o_valid,
	output mem_bus_pkg::bus_req_t o_bus_req,
	input mem_bus_pkg::bus_rsp_t i_bus_rsp
);
	import fetch_pkg::*;
	import mem_bus_pkg::*;

	addr_t pc;
	instr_t rdata;
	logic ready;
	logic stall;
	logic flush;
	fetch_entry_t push_entry;

	logic ram_rw;
	logic [`FETCH_INDEX_BITS-1:0] ram_address;
	cache_line_t ram_wdata;
	cache_line_t ram_rdata;
	logic ram_initialized;

	assign push_entry = '{pc: pc, instr: rdata};

	cache_ram #(
		.DEPTH_BITS(`FETCH_INDEX_BITS)
	) cache_ram_inst (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_rw(ram_rw),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata),
		.o_initialized(ram_initialized)
	);

	instr_cache instr_cache_inst (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_pc(pc),
		.i_stall(stall),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_bus_req(o_bus_req),
		.i_bus_rsp(i_bus_rsp),
		.o_ram_rw(ram_rw),
		.o_ram_address(ram_address),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata),
		.i_ram_initialized(ram_initialized)
	);

	pc_sequencer pc_sequencer_inst (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_ready(ready),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.o_pc(pc),
		.o_flush(flush)
	);

	fetch_queue fetch_queue_inst (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_push(ready),
		.i_entry(push_entry),
		.i_flush(flush),
		.i_pop(i_pop),
		.o_entry(o_entry),
		.o_valid(o_valid),
		.o_stall(stall)
	);

endmodule

/* test/bus_model.sv */
`timescale 1ns/1ps

module bus_model (
	input logic i_clock,
	input logic i_rst,
	input mem_bus_pkg::bus_req_t i_req,
	output mem_bus_pkg::bus_rsp_t o_rsp,
	output int o_requests
);
	import mem_bus_pkg::*;

	logic armed;
	int unsigned wait_left;

	// Memory contents are a fixed mix of the address
	function automatic bus_word_t memory_word(input bus_addr_t address);
		return (address ^ 32'hA5A5_0000) + (address >> 2);
	endfunction

	always @(posedge i_clock) begin
		if (i_rst) begin
			o_rsp <= '0;
			armed <= 1'b0;
			wait_left <= 0;
			o_requests <= 0;
		end else begin
			o_rsp.ready <= 1'b0;
			// The cycle that carries ready still shows the request, so skip it
			if (i_req.req && !o_rsp.ready) begin
				if (!armed) begin
					armed <= 1'b1;
					wait_left <= $urandom % 6;
				end else if (wait_left == 0) begin
					o_rsp.ready <= 1'b1;
					o_rsp.rdata <= memory_word(i_req.addr);
					armed <= 1'b0;
					o_requests <= o_requests + 1;
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

endmodule

/* test/fetch_tb.sv */
`include "fetch_consts.svh"

`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;
	import mem_bus_pkg::*;

	localparam int PERIOD = 40;
	localparam int BUDGET_CYCLES = 3000 + 2000;

	logic i_clock;
	logic i_rst;
	logic i_redirect;
	addr_t i_redirect_pc;
	logic i_pop;
	fetch_entry_t o_entry;
	logic o_valid;
	bus_req_t o_bus_req;
	bus_rsp_t i_bus_rsp;
	int requests;

	addr_t exp_pc;
	addr_t target;
	logic pending;
	logic pop_seen;
	addr_t head_pc;
	int pops;
	int target_hits;
	int errors;
	int tests_done;
	int c0;

	fetch_top fetch_top_inst (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.i_pop(i_pop),
		.o_entry(o_entry),
		.o_valid(o_valid),
		.o_bus_req(o_bus_req),
		.i_bus_rsp(i_bus_rsp)
	);

	bus_model bus_model_inst (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_req(o_bus_req),
		.o_rsp(i_bus_rsp),
		.o_requests(requests)
	);

	function automatic instr_t memory_word(input addr_t address);
		return (address ^ 32'hA5A5_0000) + (address >> 2);
	endfunction

	always #(PERIOD / 2) i_clock = ~i_clock;

	// Pops are decided at the falling edge and take effect on the next rising edge
	always @(negedge i_clock) begin
		pop_seen = !i_rst && i_pop && o_valid;
		head_pc = o_entry.pc;
	end

	// Reference model of the next pc that decode should see
	always @(posedge i_clock) begin
		if (i_rst) begin
			exp_pc <= `FETCH_RESET_VECTOR;
			pending <= 1'b0;
			pops <= 0;
			target_hits <= 0;
		end else begin
			if (i_redirect) begin
				pending <= 1'b1;
				target <= i_redirect_pc;
			end
			if (pop_seen) begin
				pops <= pops + 1;
				if (pending && head_pc == target) begin
					exp_pc <= target + 32'd4;
					target_hits <= target_hits + 1;
					if (!i_redirect) begin
						pending <= 1'b0;
					end
				end else begin
					exp_pc <= exp_pc + 32'd4;
				end
			end
		end
	end

	a_entry_pc: assert property (
		@(negedge i_clock) disable iff (i_rst)
		i_pop && o_valid |-> (o_entry.pc == exp_pc || (pending && o_entry.pc == target))
	) else begin
		errors++;
		$display("ERR %0t o_entry.pc got %h expected %h", $time, o_entry.pc, exp_pc);
	end

	a_entry_instr: assert property (
		@(negedge i_clock) disable iff (i_rst)
		i_pop && o_valid |-> o_entry.instr == memory_word(o_entry.pc)
	) else begin
		errors++;
		$display("ERR %0t o_entry.instr got %h expected %h", $time, o_entry.instr,
			memory_word(o_entry.pc));
	end

	task automatic pop_entries(input int n);
		int start;
		start = pops;
		@(posedge i_clock);
		i_pop <= 1'b1;
		while (pops < start + n) begin
			@(posedge i_clock);
		end
	endtask

	// Keeps popping until the redirect target reaches the head of the queue
	task automatic redirect_to(input addr_t address);
		int start;
		start = target_hits;
		@(posedge i_clock);
		i_pop <= 1'b1;
		i_redirect <= 1'b1;
		i_redirect_pc <= address;
		@(posedge i_clock);
		i_redirect <= 1'b0;
		while (target_hits == start) begin
			@(posedge i_clock);
		end
	endtask

	task automatic idle_cycles(input int n);
		@(posedge i_clock);
		i_pop <= 1'b0;
		repeat (n) @(posedge i_clock);
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d %s finished, errors so far %0d", tests_done, name, errors);
	endtask

	task automatic check_cond(input logic ok, input string what);
		assert (ok) else begin
			errors++;
			$display("Check failed at %0t: %s", $time, what);
		end
	endtask

	initial begin
		void'($urandom(32'h6c70));
		i_clock = 1'b0;
		i_rst = 1'b1;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		i_pop = 1'b0;
		errors = 0;
		tests_done = 0;
		repeat (3) @(posedge i_clock);
		@(negedge i_clock);
		check_cond(!o_valid && !o_bus_req.req, "outputs not low during reset");
		@(posedge i_clock);
		i_rst <= 1'b0;

		pop_entries(20);
		finish_test("sequential fetch");

		idle_cycles(70);
		redirect_to(32'h400);
		pop_entries(19);
		redirect_to(32'h400);
		c0 = requests;
		pop_entries(15);
		@(negedge i_clock);
		check_cond(requests == c0, "re-fetch of a cached region used the bus");
		finish_test("hits after warm-up");

		idle_cycles(10);
		c0 = requests;
		repeat (30) @(posedge i_clock);
		@(negedge i_clock);
		check_cond(o_valid, "queue empty while pop held low");
		check_cond(requests == c0 && !o_bus_req.req, "bus request raised while full");
		pop_entries(12);
		finish_test("back-pressure");

		redirect_to(32'h800);
		pop_entries(8);
		finish_test("redirect");

		redirect_to(32'hA00);
		pop_entries(3);
		redirect_to(32'hB00);
		pop_entries(3);
		c0 = requests;
		redirect_to(32'hA00);
		@(negedge i_clock);
		check_cond(requests >= c0 + 2, "aliased line did not cause a refill");
		pop_entries(3);
		finish_test("aliasing");

		repeat (400) begin
			@(posedge i_clock);
			i_pop <= 1'($urandom % 2);
		end
		idle_cycles(2);
		finish_test("random pop");

		$display("tests %0d, entries popped %0d, errors %0d", tests_done, pops, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(BUDGET_CYCLES * PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

/* fetch_cache.f */
+incdir+source
source/fetch_pkg.sv
source/mem_bus_pkg.sv
source/cache_ram.sv
source/instr_cache.sv
source/pc_sequencer.sv
source/fetch_queue.sv
source/fetch_top.sv
test/bus_model.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	-f fetch_cache.f --top-module fetch_tb -o Vfetch_tb; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vfetch_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1
